// ==== list.f ====
verilog/pci_dev_pkg.sv
verilog/pci_initiator.sv
verilog/pci_target.sv
verilog/pci_bus_port.sv
verilog/pci_device.sv
tb/tb_bus_model.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench; exit status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_top -f list.f -o tb_sim \
  && ./obj_dir/tb_sim | grep "Test completed successfully" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== tb/tb_bus_model.sv ====
module tb_bus_model #(
  parameter int MAX_WAIT = 3
) (
  input  logic                  clk,
  input  pci_dev_pkg::ad_word_t ad_out,
  input  logic                  ad_oe,
  input  logic                  cbe_out,
  input  logic                  cbe_oe,
  input  logic                  frame_n_out,
  input  logic                  frame_n_oe,
  input  logic                  irdy_n_out,
  input  logic                  irdy_n_oe,
  input  logic                  trdy_n_out,
  input  logic                  trdy_n_oe,
  input  logic                  devsel_n_out,
  input  logic                  devsel_n_oe,
  output pci_dev_pkg::ad_word_t ad,
  output logic                  cbe,
  output logic                  frame_n,
  output logic                  irdy_n,
  output logic                  trdy_n,
  output logic                  devsel_n
);
  timeunit 1ns;
  timeprecision 100ps;
  import pci_dev_pkg::*;

  // own drive of the remote party, used wherever the DUT does not drive
  ad_word_t m_ad = '0;
  logic     m_cbe = 1'b0;
  logic     m_frame_n = 1'b1;
  logic     m_irdy_n = 1'b1;
  logic     m_trdy_n = 1'b1;
  logic     m_devsel_n = 1'b1;

  // words sent by the model, words it saw on the bus
  ad_word_t tx_words [BURST_MAX];
  ad_word_t rx_words [BURST_MAX];
  int       rx_count;
  ad_word_t seen_addr;
  logic     seen_cbe;
  bit       ended_by_frame;
  bit       got_devsel;
  bit       stalled;

  assign ad = ad_oe ? ad_out : m_ad;
  assign cbe = cbe_oe ? cbe_out : m_cbe;
  assign frame_n = frame_n_oe ? frame_n_out : m_frame_n;
  assign irdy_n = irdy_n_oe ? irdy_n_out : m_irdy_n;
  assign trdy_n = trdy_n_oe ? trdy_n_out : m_trdy_n;
  assign devsel_n = devsel_n_oe ? devsel_n_out : m_devsel_n;

  task automatic advance;
    @(posedge clk);
    #1;
  endtask

  function automatic int pick_wait;
    return int'($urandom_range(MAX_WAIT, 0));
  endfunction

  // answer a burst started by the DUT initiator
  task automatic act_as_target(input bit answer);
    int guard;
    int w;
    int idx;
    bit last;
    rx_count = 0;
    ended_by_frame = 1'b0;
    stalled = 1'b0;
    guard = 0;
    @(negedge clk);
    while (!(frame_n == 1'b0 && irdy_n == 1'b1) && guard < 40)
    begin
      @(negedge clk);
      guard++;
    end
    if (guard >= 40)
    begin
      stalled = 1'b1;
      advance();
      return;
    end
    seen_addr = ad;
    seen_cbe = cbe;
    advance();
    if (!answer)
    begin
      // stay silent until the initiator gives up and releases frame
      guard = 0;
      @(negedge clk);
      while (frame_n_oe && guard < 40)
      begin
        @(negedge clk);
        guard++;
      end
      stalled = (guard >= 40);
      advance();
      return;
    end
    m_devsel_n = 1'b0;
    m_trdy_n = 1'b1;
    // read turnaround
    if (seen_cbe)
      advance();
    idx = 0;
    last = 1'b0;
    while (!last && !stalled)
    begin
      w = pick_wait();
      m_ad = tx_words[idx];
      m_trdy_n = 1'b1;
      repeat (w) advance();
      m_trdy_n = 1'b0;
      guard = 0;
      @(negedge clk);
      while (irdy_n && guard < 40)
      begin
        advance();
        @(negedge clk);
        guard++;
      end
      if (guard >= 40)
        stalled = 1'b1;
      else
      begin
        rx_words[idx] = ad;
        rx_count++;
        last = frame_n;
        idx++;
        if (!last && idx >= BURST_MAX)
          stalled = 1'b1;
      end
      advance();
    end
    ended_by_frame = last;
    m_trdy_n = 1'b1;
    m_devsel_n = 1'b1;
    m_ad = '0;
  endtask

  // run a burst towards the DUT target
  task automatic act_as_initiator(input ad_word_t addr, input bit rd, input int len);
    int guard;
    int w;
    rx_count = 0;
    got_devsel = 1'b0;
    stalled = 1'b0;
    m_ad = addr;
    m_cbe = rd;
    m_frame_n = 1'b0;
    m_irdy_n = 1'b1;
    advance();
    for (int i = 0; i < len && !stalled; i++)
    begin
      w = pick_wait();
      m_irdy_n = 1'b1;
      if (!rd)
        m_ad = tx_words[i];
      repeat (w)
      begin
        @(negedge clk);
        if (!devsel_n)
          got_devsel = 1'b1;
        advance();
      end
      m_irdy_n = 1'b0;
      m_frame_n = (i == len - 1);
      guard = 0;
      @(negedge clk);
      if (!devsel_n)
        got_devsel = 1'b1;
      while (trdy_n && guard < 12)
      begin
        advance();
        @(negedge clk);
        if (!devsel_n)
          got_devsel = 1'b1;
        guard++;
      end
      if (trdy_n)
        stalled = 1'b1;
      else
      begin
        rx_words[i] = ad;
        rx_count++;
      end
      advance();
    end
    m_frame_n = 1'b1;
    m_irdy_n = 1'b1;
    m_cbe = 1'b0;
    m_ad = '0;
  endtask

endmodule

// ==== tb/tb_top.sv ====
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import pci_dev_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int MAX_WAIT = 3;
  localparam int NUM_TESTS = 9;
  // burst, waits, buffer fill and readback, idle margin
  localparam int TEST_CYCLES = BURST_MAX + DEVSEL_TIMEOUT + MAX_WAIT * BURST_MAX
    + 2 * BURST_MAX + 20;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES + 16;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     host_wr;
  idx_t     host_idx;
  ad_word_t host_wdata;
  ad_word_t host_rdata;
  logic     start;
  logic     start_read;
  ad_word_t start_addr;
  idx_t     start_len;
  logic     gnt_n = 1'b1;
  logic     req;
  logic     busy;
  logic     done;
  logic     aborted;
  ad_word_t ad_out;
  logic     ad_oe;
  logic     cbe_out;
  logic     cbe_oe;
  logic     frame_n_out;
  logic     frame_n_oe;
  logic     irdy_n_out;
  logic     irdy_n_oe;
  logic     trdy_n_out;
  logic     trdy_n_oe;
  logic     devsel_n_out;
  logic     devsel_n_oe;
  ad_word_t ad;
  logic     cbe;
  logic     frame_n;
  logic     irdy_n;
  logic     trdy_n;
  logic     devsel_n;

  ad_word_t ref_buf [BURST_MAX];
  int       errors = 0;
  int       errors_before = 0;
  int       tests_run = 0;
  int       done_cnt = 0;
  int       abort_cnt = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // arbiter grants whatever was requested
  always @(posedge clk)
  begin
    #1;
    gnt_n <= !req;
  end

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (done)
        done_cnt++;
      if (aborted)
        abort_cnt++;
    end
  end

  pci_device DUT (
    .clk, .rst_n, .host_wr, .host_idx, .host_wdata,
    .start, .start_read, .start_addr, .start_len, .gnt_n,
    .ad_in (ad), .cbe_in (cbe), .frame_n_in (frame_n), .irdy_n_in (irdy_n),
    .trdy_n_in (trdy_n), .devsel_n_in (devsel_n),
    .host_rdata, .req, .busy, .done, .aborted,
    .ad_out, .ad_oe, .cbe_out, .cbe_oe, .frame_n_out, .frame_n_oe,
    .irdy_n_out, .irdy_n_oe, .trdy_n_out, .trdy_n_oe, .devsel_n_out, .devsel_n_oe
  );

  tb_bus_model #(
    .MAX_WAIT (MAX_WAIT)
  ) bus_model (
    .clk, .ad_out, .ad_oe, .cbe_out, .cbe_oe, .frame_n_out, .frame_n_oe,
    .irdy_n_out, .irdy_n_oe, .trdy_n_out, .trdy_n_oe, .devsel_n_out, .devsel_n_oe,
    .ad, .cbe, .frame_n, .irdy_n, .trdy_n, .devsel_n
  );

  task automatic step;
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string name, input ad_word_t got, input ad_word_t exp);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond)
    else
    begin
      $display("%0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_before)
      $display("%s: pass", name);
    else
      $display("%s: FAIL with %0d errors", name, errors - errors_before);
    errors_before = errors;
  endtask

  task automatic host_fill;
    for (int i = 0; i < BURST_MAX; i++)
    begin
      ref_buf[i] = $urandom;
      host_wr = 1'b1;
      host_idx = idx_t'(i);
      host_wdata = ref_buf[i];
      step();
    end
    host_wr = 1'b0;
  endtask

  task automatic host_verify;
    for (int i = 0; i < BURST_MAX; i++)
    begin
      host_idx = idx_t'(i);
      @(negedge clk);
      check_word($sformatf("host_rdata[%0d]", i), host_rdata, ref_buf[i]);
      step();
    end
  endtask

  task automatic run_initiator(input bit rd, input bit answer, input int len);
    ad_word_t addr;
    int guard;
    addr = $urandom;
    // keep the DUT's own target out of the burst
    if (addr == DEFAULT_DEVICE_ID)
      addr = ~addr;
    for (int i = 0; i < BURST_MAX; i++)
      bus_model.tx_words[i] = $urandom;
    done_cnt = 0;
    abort_cnt = 0;
    start_addr = addr;
    start_read = rd;
    start_len = idx_t'(len);
    start = 1'b1;
    step();
    start = 1'b0;
    check_true(busy, "busy did not rise in the cycle after start");
    check_true(req, "req did not rise in the cycle after start");
    bus_model.act_as_target(answer);
    check_true(!bus_model.stalled, "bus model timed out waiting for the initiator");
    guard = 0;
    @(negedge clk);
    while (busy && guard < 60)
    begin
      @(negedge clk);
      guard++;
    end
    check_true(!busy, "initiator did not return to idle");
    step();
    check_word("ad in address phase", bus_model.seen_addr, addr);
    check_word("cbe in address phase", 32'(bus_model.seen_cbe), 32'(rd));
    check_word("done pulses", 32'(done_cnt), 32'd1);
    check_word("aborted pulses", 32'(abort_cnt), answer ? 32'd0 : 32'd1);
    if (answer)
    begin
      check_word("transfer count", 32'(bus_model.rx_count), 32'(len));
      check_true(bus_model.ended_by_frame, "burst did not end with frame_n high");
      for (int i = 0; i < len && i < bus_model.rx_count; i++)
      begin
        if (rd)
          ref_buf[i] = bus_model.tx_words[i];
        else
          check_word($sformatf("write word %0d", i), bus_model.rx_words[i], ref_buf[i]);
      end
    end
    host_verify();
  endtask

  initial
  begin
    int len;
    void'($urandom(85));
    rst_n = 1'b0;
    host_wr = 1'b0;
    host_idx = '0;
    host_wdata = '0;
    start = 1'b0;
    start_read = 1'b0;
    start_addr = '0;
    start_len = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) step();

    host_fill();
    host_verify();
    finish_test("host access");

    repeat (2)
    begin
      host_fill();
      run_initiator(1'b0, 1'b1, int'($urandom_range(BURST_MAX, 1)));
      finish_test("initiator write");
      repeat (3) step();
    end

    repeat (2)
    begin
      host_fill();
      run_initiator(1'b1, 1'b1, int'($urandom_range(BURST_MAX, 1)));
      finish_test("initiator read");
      repeat (3) step();
    end

    host_fill();
    run_initiator(1'b0, 1'b0, int'($urandom_range(BURST_MAX, 1)));
    finish_test("master abort");
    repeat (3) step();

    len = int'($urandom_range(BURST_MAX, 1));
    for (int i = 0; i < BURST_MAX; i++)
      bus_model.tx_words[i] = $urandom;
    bus_model.act_as_initiator(DEFAULT_DEVICE_ID, 1'b0, len);
    check_true(!bus_model.stalled, "target write burst stalled");
    check_true(bus_model.got_devsel, "target never asserted devsel_n on write");
    for (int i = 0; i < len; i++)
      ref_buf[i] = bus_model.tx_words[i];
    repeat (3) step();
    host_verify();
    finish_test("target write");

    bus_model.act_as_initiator(DEFAULT_DEVICE_ID, 1'b1, len);
    check_true(!bus_model.stalled, "target read burst stalled");
    check_word("read word count", 32'(bus_model.rx_count), 32'(len));
    for (int i = 0; i < len && i < bus_model.rx_count; i++)
      check_word($sformatf("read word %0d", i), bus_model.rx_words[i], ref_buf[i]);
    repeat (3) step();
    finish_test("target read");

    for (int i = 0; i < BURST_MAX; i++)
      bus_model.tx_words[i] = $urandom;
    bus_model.act_as_initiator(DEFAULT_DEVICE_ID ^ 32'h10, 1'b0,
      int'($urandom_range(BURST_MAX, 1)));
    check_true(!bus_model.got_devsel, "target claimed a burst to another address");
    check_true(bus_model.stalled, "burst to another address completed");
    repeat (3) step();
    host_verify();
    finish_test("target address mismatch");

    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== verilog/pci_bus_port.sv ====
module pci_bus_port (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pci_dev_pkg::ad_word_t ad_in,
  input  logic                  init_owns_ad,
  input  logic                  init_addr_phase,
  input  logic                  init_capture,
  input  logic                  tgt_owns_ad,
  input  logic                  tgt_capture,
  input  logic                  host_wr,
  input  pci_dev_pkg::ad_word_t init_addr,
  input  pci_dev_pkg::ad_word_t host_wdata,
  input  pci_dev_pkg::idx_t     init_idx,
  input  pci_dev_pkg::idx_t     tgt_idx,
  input  pci_dev_pkg::idx_t     host_idx,
  output pci_dev_pkg::ad_word_t ad_out,
  output logic                  ad_oe,
  output pci_dev_pkg::ad_word_t host_rdata
);
  import pci_dev_pkg::*;

  ad_word_t burst_buf [BURST_MAX];

  // bus captures win over the host port
  always_ff @(posedge clk)
  begin
    if (init_capture)
      burst_buf[init_idx] <= ad_in;
    else if (tgt_capture)
      burst_buf[tgt_idx] <= ad_in;
    else if (host_wr)
      burst_buf[host_idx] <= host_wdata;
  end

  always_comb
  begin
    if (init_owns_ad)
    begin
      if (init_addr_phase)
        ad_out = init_addr;
      else
        ad_out = burst_buf[init_idx];
    end
    else if (tgt_owns_ad)
      ad_out = burst_buf[tgt_idx];
    else
      ad_out = '0;
  end

  assign ad_oe = init_owns_ad || tgt_owns_ad;
  assign host_rdata = burst_buf[host_idx];

  // the two machines share one buffer and one ad driver
  a_single_owner: assert property (@(posedge clk) disable iff (!rst_n)
    !(init_owns_ad && tgt_owns_ad) && !(init_capture && tgt_capture));

endmodule

// ==== verilog/pci_dev_pkg.sv ====
package pci_dev_pkg;

  localparam int AD_W = 32;
  localparam int BURST_MAX = 10;
  localparam int IDX_W = 4;
  localparam int DEVSEL_TIMEOUT = 4;
  localparam int TMO_W = $clog2(DEVSEL_TIMEOUT + 1);
  localparam logic [AD_W-1:0] DEFAULT_DEVICE_ID = 32'h4000_0100;

  typedef logic [AD_W-1:0] ad_word_t;
  typedef logic [IDX_W-1:0] idx_t;

  // initiator phases
  typedef enum logic [2:0] {
    I_IDLE,
    I_REQ,
    I_ADDR,
    I_TURN,
    I_DATA,
    I_RECOVER
  } init_state_t;

  // target phases
  typedef enum logic [1:0] {
    T_IDLE,
    T_TURN,
    T_DATA,
    T_RECOVER
  } tgt_state_t;

endpackage

// ==== verilog/pci_device.sv ====
module pci_device #(
  parameter pci_dev_pkg::ad_word_t DEVICE_ID = pci_dev_pkg::DEFAULT_DEVICE_ID
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  host_wr,
  input  pci_dev_pkg::idx_t     host_idx,
  input  pci_dev_pkg::ad_word_t host_wdata,
  input  logic                  start,
  input  logic                  start_read,
  input  pci_dev_pkg::ad_word_t start_addr,
  input  pci_dev_pkg::idx_t     start_len,
  input  logic                  gnt_n,
  input  pci_dev_pkg::ad_word_t ad_in,
  input  logic                  cbe_in,
  input  logic                  frame_n_in,
  input  logic                  irdy_n_in,
  input  logic                  trdy_n_in,
  input  logic                  devsel_n_in,
  output pci_dev_pkg::ad_word_t host_rdata,
  output logic                  req,
  output logic                  busy,
  output logic                  done,
  output logic                  aborted,
  output pci_dev_pkg::ad_word_t ad_out,
  output logic                  ad_oe,
  output logic                  cbe_out,
  output logic                  cbe_oe,
  output logic                  frame_n_out,
  output logic                  frame_n_oe,
  output logic                  irdy_n_out,
  output logic                  irdy_n_oe,
  output logic                  trdy_n_out,
  output logic                  trdy_n_oe,
  output logic                  devsel_n_out,
  output logic                  devsel_n_oe
);
  import pci_dev_pkg::*;

  logic     init_owns_ad;
  logic     init_addr_phase;
  logic     init_capture;
  ad_word_t init_addr;
  idx_t     init_idx;
  logic     tgt_owns_ad;
  logic     tgt_capture;
  idx_t     tgt_idx;

  pci_initiator u_initiator (
    .clk, .rst_n, .start, .start_read, .start_addr, .start_len,
    .gnt_n, .frame_n_in, .irdy_n_in, .trdy_n_in, .devsel_n_in,
    .req, .frame_n_out, .frame_n_oe, .irdy_n_out, .irdy_n_oe,
    .cbe_out, .cbe_oe, .init_owns_ad, .init_addr_phase, .init_capture,
    .init_addr, .init_idx, .busy, .done, .aborted
  );

  pci_target #(
    .DEVICE_ID (DEVICE_ID)
  ) u_target (
    .clk, .rst_n, .frame_n_in, .irdy_n_in, .cbe_in, .ad_in,
    .devsel_n_out, .devsel_n_oe, .trdy_n_out, .trdy_n_oe,
    .tgt_owns_ad, .tgt_capture, .tgt_idx
  );

  pci_bus_port u_bus_port (
    .clk, .rst_n, .ad_in,
    .init_owns_ad, .init_addr_phase, .init_capture,
    .tgt_owns_ad, .tgt_capture, .host_wr,
    .init_addr, .host_wdata, .init_idx, .tgt_idx, .host_idx,
    .ad_out, .ad_oe, .host_rdata
  );

endmodule

// ==== verilog/pci_initiator.sv ====
module pci_initiator (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  start_read,
  input  pci_dev_pkg::ad_word_t start_addr,
  input  pci_dev_pkg::idx_t     start_len,
  input  logic                  gnt_n,
  input  logic                  frame_n_in,
  input  logic                  irdy_n_in,
  input  logic                  trdy_n_in,
  input  logic                  devsel_n_in,
  output logic                  req,
  output logic                  frame_n_out,
  output logic                  frame_n_oe,
  output logic                  irdy_n_out,
  output logic                  irdy_n_oe,
  output logic                  cbe_out,
  output logic                  cbe_oe,
  output logic                  init_owns_ad,
  output logic                  init_addr_phase,
  output logic                  init_capture,
  output pci_dev_pkg::ad_word_t init_addr,
  output pci_dev_pkg::idx_t     init_idx,
  output logic                  busy,
  output logic                  done,
  output logic                  aborted
);
  import pci_dev_pkg::*;

  init_state_t      state;
  ad_word_t         addr_q;
  logic             rd_q;
  idx_t             idx;
  idx_t             remain;
  logic [TMO_W-1:0] tmo_cnt;
  logic             devsel_seen;
  logic             watching;
  logic             tmo_hit;
  logic             abort_q;
  logic             frame_q;
  logic             frame_oe_q;
  logic             irdy_oe_q;
  logic             bus_free;
  logic             xfer;

  assign bus_free = !gnt_n && frame_n_in && irdy_n_in;
  assign xfer = (state == I_DATA) && !irdy_n_in && !trdy_n_in;
  assign watching = (state == I_TURN || state == I_DATA) && !devsel_seen;
  assign tmo_hit = watching && devsel_n_in && (tmo_cnt == TMO_W'(DEVSEL_TIMEOUT - 1));

  // devsel watch, restarted by every address phase
  always_ff @(posedge clk)
  begin
    if (!rst_n || state == I_ADDR)
    begin
      devsel_seen <= 1'b0;
      tmo_cnt <= '0;
    end
    else if (watching)
    begin
      if (!devsel_n_in)
        devsel_seen <= 1'b1;
      else
        tmo_cnt <= tmo_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= I_IDLE;
      rd_q <= 1'b1;
      idx <= '0;
      remain <= '0;
      abort_q <= 1'b0;
      frame_q <= 1'b1;
      frame_oe_q <= 1'b0;
      irdy_oe_q <= 1'b0;
    end
    else if (tmo_hit)
    begin
      // master abort
      abort_q <= 1'b1;
      frame_q <= 1'b1;
      state <= I_RECOVER;
    end
    else
    begin
      case (state)
        I_IDLE:
          if (start)
          begin
            addr_q <= start_addr;
            rd_q <= start_read;
            if (start_len == '0)
              remain <= idx_t'(1);
            else if (start_len > BURST_MAX)
              remain <= idx_t'(BURST_MAX);
            else
              remain <= start_len;
            state <= I_REQ;
          end
        I_REQ:
          if (bus_free)
          begin
            idx <= '0;
            abort_q <= 1'b0;
            frame_q <= 1'b0;
            frame_oe_q <= 1'b1;
            irdy_oe_q <= 1'b1;
            state <= I_ADDR;
          end
        I_ADDR:
          if (rd_q)
            state <= I_TURN;
          else
          begin
            frame_q <= (remain == idx_t'(1));
            state <= I_DATA;
          end
        I_TURN:
        begin
          frame_q <= (remain == idx_t'(1));
          state <= I_DATA;
        end
        I_DATA:
          if (xfer)
          begin
            if (remain == idx_t'(1))
              state <= I_RECOVER;
            else
            begin
              idx <= idx + 1'b1;
              remain <= remain - 1'b1;
              // next transfer is the last one
              if (remain == idx_t'(2))
                frame_q <= 1'b1;
            end
          end
        I_RECOVER:
        begin
          frame_oe_q <= 1'b0;
          irdy_oe_q <= 1'b0;
          state <= I_IDLE;
        end
        default:
          state <= I_IDLE;
      endcase
    end
  end

  assign req = (state == I_REQ);
  assign frame_n_out = frame_q;
  assign frame_n_oe = frame_oe_q;
  assign irdy_n_out = !(state == I_TURN || state == I_DATA);
  assign irdy_n_oe = irdy_oe_q;
  assign cbe_out = rd_q;
  assign cbe_oe = frame_oe_q;
  assign init_owns_ad = (state == I_ADDR) || (state == I_DATA && !rd_q);
  assign init_addr_phase = (state == I_ADDR);
  assign init_capture = xfer && rd_q;
  assign init_addr = addr_q;
  assign init_idx = idx;
  assign busy = (state != I_IDLE);
  assign done = (state == I_RECOVER);
  assign aborted = done && abort_q;

  // irdy is only asserted while frame and irdy are both driven
  a_irdy_needs_frame: assert property (@(posedge clk) disable iff (!rst_n)
    !irdy_n_out |-> (irdy_n_oe && frame_n_oe));

  a_init_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    init_idx < BURST_MAX);

endmodule

// ==== verilog/pci_target.sv ====
module pci_target #(
  parameter pci_dev_pkg::ad_word_t DEVICE_ID = pci_dev_pkg::DEFAULT_DEVICE_ID
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  frame_n_in,
  input  logic                  irdy_n_in,
  input  logic                  cbe_in,
  input  pci_dev_pkg::ad_word_t ad_in,
  output logic                  devsel_n_out,
  output logic                  devsel_n_oe,
  output logic                  trdy_n_out,
  output logic                  trdy_n_oe,
  output logic                  tgt_owns_ad,
  output logic                  tgt_capture,
  output pci_dev_pkg::idx_t     tgt_idx
);
  import pci_dev_pkg::*;

  tgt_state_t state;
  logic       frame_d;
  logic       rd_q;
  logic       addr_hit;
  logic       xfer;
  logic       claim;
  idx_t       idx;

  // address phase is the falling frame edge with irdy still high
  assign addr_hit = !frame_n_in && frame_d && irdy_n_in && (ad_in == DEVICE_ID);

  // trdy is always low in the data state, so irdy alone decides
  assign xfer = (state == T_DATA) && !irdy_n_in;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      frame_d <= 1'b1;
    else
      frame_d <= frame_n_in;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= T_IDLE;
      rd_q <= 1'b0;
      idx <= '0;
    end
    else
    begin
      case (state)
        T_IDLE:
          if (addr_hit)
          begin
            rd_q <= cbe_in;
            idx <= '0;
            state <= cbe_in ? T_TURN : T_DATA;
          end
        T_TURN:
          state <= T_DATA;
        T_DATA:
          if (xfer)
          begin
            if (frame_n_in)
              state <= T_RECOVER;
            else
              idx <= idx + 1'b1;
          end
        T_RECOVER:
          state <= T_IDLE;
        default:
          state <= T_IDLE;
      endcase
    end
  end

  assign claim = (state == T_TURN) || (state == T_DATA);

  assign devsel_n_out = !claim;
  assign devsel_n_oe = (state != T_IDLE);
  assign trdy_n_out = (state != T_DATA);
  assign trdy_n_oe = (state != T_IDLE);
  assign tgt_owns_ad = (state == T_DATA) && rd_q;
  assign tgt_capture = xfer && !rd_q;
  assign tgt_idx = idx;

  // trdy only under devsel, and a read answers after a devsel-only turnaround
  a_trdy_under_devsel: assert property (@(posedge clk) disable iff (!rst_n)
    (trdy_n_oe && !trdy_n_out) |-> !devsel_n_out && (!rd_q || $past(!devsel_n_out)));

  // an overlong burst from a remote initiator would run past the buffer
  a_tgt_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    tgt_idx < BURST_MAX);

endmodule
